/* include/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

`define RV_XLEN        32           // Data and address width
`define RV_REG_AW      5
`define RV_NUM_REGS    32

// First fetch address after reset
`define RV_RESET_PC    32'h0000_0000
`define RV_INSTR_BYTES 4            // PC step

`endif

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Major opcodes kept by this core
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011
  } rv_opcode_e;

  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } rv_branch_f3_e;

  typedef enum logic [2:0] {
    f3_add  = 3'b000,               // Also sub for register form
    f3_sll  = 3'b001,
    f3_slt  = 3'b010,
    f3_sltu = 3'b011,
    f3_xor  = 3'b100,
    f3_sr   = 3'b101,               // srl or sra by bit 30
    f3_or   = 3'b110,
    f3_and  = 3'b111
  } rv_arith_f3_e;

  parameter logic [2:0] f3_word = 3'b010; // Only full word accesses

endpackage

/* verilog/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } rv_alu_op_e;

  typedef enum logic [2:0] {
    cmp_eq, cmp_ne, cmp_lt, cmp_ge, cmp_ltu, cmp_geu
  } rv_cmp_op_e;

  typedef enum logic [2:0] {wb_alu, wb_cmp, wb_pc4, wb_mem} rv_wb_sel_e;
  typedef enum logic {src_a_rs1, src_a_pc} rv_src_a_e;
  typedef enum logic {src_b_rs2, src_b_imm} rv_src_b_e;

  // All zero is a bubble
  typedef struct packed {
    rv_alu_op_e alu_op;
    rv_cmp_op_e cmp_op;
    rv_src_a_e  src_a;
    rv_src_b_e  src_b;
    logic       branch;
    logic       jump;             // jal and jalr
    logic       jalr;
    logic       mem_read;
    logic       mem_write;
    rv_wb_sel_e wb_sel;
    logic       rd_valid;
  } rv_ctrl_word_t;

endpackage

/* verilog/rv_decoder.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_decoder (
  input  logic [`RV_XLEN-1:0]    i_instr,
  output rv_ctrl_pkg::rv_ctrl_word_t o_ctrl,
  output logic [`RV_XLEN-1:0]    o_imm,
  output logic [`RV_REG_AW-1:0]  o_rs1,
  output logic [`RV_REG_AW-1:0]  o_rs2,
  output logic [`RV_REG_AW-1:0]  o_rd
);

  logic [2:0] funct3;
  logic       alt;                 // Instruction bit 30

  // Shared by register-immediate and register-register forms
  function automatic rv_ctrl_pkg::rv_alu_op_e arith_op(input logic [2:0] f3,
                                                       input logic sub_sra);
    rv_ctrl_pkg::rv_alu_op_e op;
    case (rv_isa_pkg::rv_arith_f3_e'(f3))
      rv_isa_pkg::f3_add:  op = sub_sra ? rv_ctrl_pkg::alu_sub : rv_ctrl_pkg::alu_add;
      rv_isa_pkg::f3_sll:  op = rv_ctrl_pkg::alu_sll;
      rv_isa_pkg::f3_slt:  op = rv_ctrl_pkg::alu_slt;
      rv_isa_pkg::f3_sltu: op = rv_ctrl_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:  op = rv_ctrl_pkg::alu_xor;
      rv_isa_pkg::f3_sr:   op = sub_sra ? rv_ctrl_pkg::alu_sra : rv_ctrl_pkg::alu_srl;
      rv_isa_pkg::f3_or:   op = rv_ctrl_pkg::alu_or;
      default:             op = rv_ctrl_pkg::alu_and;
    endcase
    return op;
  endfunction

  assign funct3 = i_instr[14:12];
  assign alt    = i_instr[30];
  assign o_rs1  = i_instr[19:15];
  assign o_rs2  = i_instr[24:20];
  assign o_rd   = i_instr[11:7];

  always_comb begin
    o_ctrl = '0;
    o_imm  = {{20{i_instr[31]}}, i_instr[31:20]}; // I-type unless changed below
    case (rv_isa_pkg::rv_opcode_e'(i_instr[6:0]))
      rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc: begin
        o_imm           = {i_instr[31:12], 12'b0};
        o_ctrl.alu_op   = i_instr[5] ? rv_ctrl_pkg::alu_pass_b : rv_ctrl_pkg::alu_add;
        o_ctrl.src_a    = rv_ctrl_pkg::src_a_pc;
        o_ctrl.src_b    = rv_ctrl_pkg::src_b_imm;
        o_ctrl.rd_valid = 1'b1;
      end
      rv_isa_pkg::op_imm, rv_isa_pkg::op_reg: begin
        o_ctrl.src_b    = i_instr[5] ? rv_ctrl_pkg::src_b_rs2 : rv_ctrl_pkg::src_b_imm;
        // Bit 30 of an immediate only selects sra
        o_ctrl.alu_op   = arith_op(funct3, alt && (i_instr[5] ||
                                   funct3 == rv_isa_pkg::f3_sr));
        o_ctrl.rd_valid = 1'b1;
        if (funct3 == rv_isa_pkg::f3_slt || funct3 == rv_isa_pkg::f3_sltu) begin
          o_ctrl.cmp_op = funct3[0] ? rv_ctrl_pkg::cmp_ltu : rv_ctrl_pkg::cmp_lt;
          o_ctrl.wb_sel = rv_ctrl_pkg::wb_cmp;
        end
      end
      rv_isa_pkg::op_jal: begin
        o_imm           = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                           i_instr[30:21], 1'b0};
        o_ctrl.src_a    = rv_ctrl_pkg::src_a_pc;
        o_ctrl.src_b    = rv_ctrl_pkg::src_b_imm;
        o_ctrl.jump     = 1'b1;
        o_ctrl.wb_sel   = rv_ctrl_pkg::wb_pc4;
        o_ctrl.rd_valid = 1'b1;
      end
      rv_isa_pkg::op_jalr: begin
        o_ctrl.src_b    = rv_ctrl_pkg::src_b_imm; // Target is rs1 + imm
        o_ctrl.jump     = 1'b1;
        o_ctrl.jalr     = 1'b1;
        o_ctrl.wb_sel   = rv_ctrl_pkg::wb_pc4;
        o_ctrl.rd_valid = 1'b1;
      end
      rv_isa_pkg::op_branch: begin
        o_imm        = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                        i_instr[11:8], 1'b0};
        o_ctrl.src_a = rv_ctrl_pkg::src_a_pc;
        o_ctrl.src_b = rv_ctrl_pkg::src_b_imm;
        case (rv_isa_pkg::rv_branch_f3_e'(funct3))
          rv_isa_pkg::br_beq:  o_ctrl.cmp_op = rv_ctrl_pkg::cmp_eq;
          rv_isa_pkg::br_bne:  o_ctrl.cmp_op = rv_ctrl_pkg::cmp_ne;
          rv_isa_pkg::br_blt:  o_ctrl.cmp_op = rv_ctrl_pkg::cmp_lt;
          rv_isa_pkg::br_bge:  o_ctrl.cmp_op = rv_ctrl_pkg::cmp_ge;
          rv_isa_pkg::br_bltu: o_ctrl.cmp_op = rv_ctrl_pkg::cmp_ltu;
          default:             o_ctrl.cmp_op = rv_ctrl_pkg::cmp_geu;
        endcase
        o_ctrl.branch = (funct3[2:1] != 2'b01); // 010 and 011 are not branches
      end
      rv_isa_pkg::op_load: begin
        o_ctrl.src_b    = rv_ctrl_pkg::src_b_imm;
        o_ctrl.mem_read = (funct3 == rv_isa_pkg::f3_word);
        o_ctrl.wb_sel   = rv_ctrl_pkg::wb_mem;
        o_ctrl.rd_valid = (funct3 == rv_isa_pkg::f3_word);
      end
      rv_isa_pkg::op_store: begin
        o_imm            = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
        o_ctrl.src_b     = rv_ctrl_pkg::src_b_imm;
        o_ctrl.mem_write = (funct3 == rv_isa_pkg::f3_word);
      end
      default: o_ctrl = '0;         // Unsupported opcode passes as a bubble
    endcase
  end

endmodule

/* verilog/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_read_en,
  input  logic [`RV_REG_AW-1:0] i_rs1,
  input  logic [`RV_REG_AW-1:0] i_rs2,
  input  logic                  i_we,
  input  logic [`RV_REG_AW-1:0] i_rd,
  input  logic [`RV_XLEN-1:0]   i_wdata,
  output logic [`RV_XLEN-1:0]   o_rs1_data,
  output logic [`RV_XLEN-1:0]   o_rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (i_we && i_rd != '0)
      regs[i_rd] <= i_wdata;
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_rs1_data <= '0;
      o_rs2_data <= '0;
    end else if (i_read_en) begin
      if (i_rs1 == '0)
        o_rs1_data <= '0;
      else
        o_rs1_data <= (i_we && i_rd == i_rs1) ? i_wdata : regs[i_rs1]; // Write-through
      if (i_rs2 == '0)
        o_rs2_data <= '0;
      else
        o_rs2_data <= (i_we && i_rd == i_rs2) ? i_wdata : regs[i_rs2];
    end
  end

endmodule

/* verilog/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_execute (
  input  rv_ctrl_pkg::rv_ctrl_word_t i_ctrl,
  input  logic [`RV_XLEN-1:0]        i_pc,
  input  logic [`RV_XLEN-1:0]        i_imm,
  input  logic [`RV_REG_AW-1:0]      i_rs1,
  input  logic [`RV_REG_AW-1:0]      i_rs2,
  input  logic [`RV_XLEN-1:0]        i_rs1_data,
  input  logic [`RV_XLEN-1:0]        i_rs2_data,
  input  logic [`RV_REG_AW-1:0]      i_mem_rd,
  input  rv_ctrl_pkg::rv_ctrl_word_t i_mem_ctrl,
  input  logic [`RV_XLEN-1:0]        i_mem_result,
  input  logic [`RV_REG_AW-1:0]      i_wb_rd,
  input  logic                       i_wb_valid,
  input  logic [`RV_XLEN-1:0]        i_wb_data,
  output logic [`RV_XLEN-1:0]        o_alu_result,
  output logic                       o_cmp_result,
  output logic [`RV_XLEN-1:0]        o_store_data,
  output logic [`RV_XLEN-1:0]        o_target,
  output logic                       o_redirect,
  output logic                       o_load_use
);

  logic                mem_hit1, mem_hit2;
  logic                wb_hit1, wb_hit2;
  logic                rs1_used, rs2_used;
  logic [`RV_XLEN-1:0] rs1_val, rs2_val;
  logic [`RV_XLEN-1:0] op_a, op_b, cmp_b;
  logic [4:0]          shamt;

  // Producers in MEM and WB that write a nonzero register
  assign mem_hit1 = i_mem_ctrl.rd_valid && i_mem_rd != '0 && i_mem_rd == i_rs1;
  assign mem_hit2 = i_mem_ctrl.rd_valid && i_mem_rd != '0 && i_mem_rd == i_rs2;
  assign wb_hit1  = i_wb_valid && i_wb_rd != '0 && i_wb_rd == i_rs1;
  assign wb_hit2  = i_wb_valid && i_wb_rd != '0 && i_wb_rd == i_rs2;

  assign rs1_val = mem_hit1 ? i_mem_result : (wb_hit1 ? i_wb_data : i_rs1_data);
  assign rs2_val = mem_hit2 ? i_mem_result : (wb_hit2 ? i_wb_data : i_rs2_data);

  assign rs1_used = (i_ctrl.src_a == rv_ctrl_pkg::src_a_rs1) || i_ctrl.branch;
  assign rs2_used = (i_ctrl.src_b == rv_ctrl_pkg::src_b_rs2) || i_ctrl.branch ||
                    i_ctrl.mem_write;

  // Load data is not ready until WB
  assign o_load_use = i_mem_ctrl.mem_read &&
                      ((rs1_used && mem_hit1) || (rs2_used && mem_hit2));

  assign op_a  = (i_ctrl.src_a == rv_ctrl_pkg::src_a_pc) ? i_pc : rs1_val;
  assign op_b  = (i_ctrl.src_b == rv_ctrl_pkg::src_b_imm) ? i_imm : rs2_val;
  assign cmp_b = i_ctrl.branch ? rs2_val : op_b; // slti compares with the immediate
  assign shamt = op_b[4:0];

  always_comb begin
    case (i_ctrl.alu_op)
      rv_ctrl_pkg::alu_add:    o_alu_result = op_a + op_b;
      rv_ctrl_pkg::alu_sub:    o_alu_result = op_a - op_b;
      rv_ctrl_pkg::alu_sll:    o_alu_result = op_a << shamt;
      rv_ctrl_pkg::alu_slt:    o_alu_result = `RV_XLEN'($signed(op_a) < $signed(op_b));
      rv_ctrl_pkg::alu_sltu:   o_alu_result = `RV_XLEN'(op_a < op_b);
      rv_ctrl_pkg::alu_xor:    o_alu_result = op_a ^ op_b;
      rv_ctrl_pkg::alu_srl:    o_alu_result = op_a >> shamt;
      rv_ctrl_pkg::alu_sra:    o_alu_result = $unsigned($signed(op_a) >>> shamt);
      rv_ctrl_pkg::alu_or:     o_alu_result = op_a | op_b;
      rv_ctrl_pkg::alu_and:    o_alu_result = op_a & op_b;
      rv_ctrl_pkg::alu_pass_b: o_alu_result = op_b; // lui
      default:                 o_alu_result = '0;
    endcase
  end

  always_comb begin
    case (i_ctrl.cmp_op)
      rv_ctrl_pkg::cmp_eq:  o_cmp_result = (rs1_val == cmp_b);
      rv_ctrl_pkg::cmp_ne:  o_cmp_result = (rs1_val != cmp_b);
      rv_ctrl_pkg::cmp_lt:  o_cmp_result = ($signed(rs1_val) < $signed(cmp_b));
      rv_ctrl_pkg::cmp_ge:  o_cmp_result = ($signed(rs1_val) >= $signed(cmp_b));
      rv_ctrl_pkg::cmp_ltu: o_cmp_result = (rs1_val < cmp_b);
      rv_ctrl_pkg::cmp_geu: o_cmp_result = (rs1_val >= cmp_b);
      default:              o_cmp_result = 1'b0;
    endcase
  end

  assign o_store_data = rs2_val;
  assign o_target     = i_ctrl.jalr ? {o_alu_result[`RV_XLEN-1:1], 1'b0} : o_alu_result;
  assign o_redirect   = i_ctrl.jump || (i_ctrl.branch && o_cmp_result);

endmodule

/* verilog/rv_hazard_unit.sv */
`timescale 1ns/1ps

module rv_hazard_unit (
  input  logic i_imem_resp,
  input  logic i_dmem_resp,
  input  logic i_dmem_access,
  input  logic i_load_use,
  input  logic i_redirect,
  output logic o_freeze,
  output logic o_hold_front,
  output logic o_flush_front,
  output logic o_bubble_mem
);

  // Any memory wait stops every state element
  assign o_freeze = !i_imem_resp || (i_dmem_access && !i_dmem_resp);

  // Load-use keeps PC, IF/ID and ID/EX
  assign o_hold_front = !o_freeze && i_load_use;
  assign o_bubble_mem = o_hold_front;

  // A redirect on stale operands is not taken while load-use holds EX
  assign o_flush_front = !o_freeze && !i_load_use && i_redirect;

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core (
  input  logic                clk,
  input  logic                i_reset,
  output logic [`RV_XLEN-1:0] o_imem_addr,
  output logic                o_imem_read,
  input  logic                i_imem_resp,
  input  logic [`RV_XLEN-1:0] i_imem_rdata,
  output logic [`RV_XLEN-1:0] o_dmem_addr,
  output logic                o_dmem_read,
  output logic                o_dmem_write,
  output logic [`RV_XLEN-1:0] o_dmem_wdata,
  input  logic                i_dmem_resp,
  input  logic [`RV_XLEN-1:0] i_dmem_rdata
);

  logic [`RV_XLEN-1:0]        pc;
  logic [`RV_XLEN-1:0]        id_instr, id_pc, id_imm;
  rv_ctrl_pkg::rv_ctrl_word_t id_ctrl, ex_ctrl, mem_ctrl, wb_ctrl;
  logic [`RV_REG_AW-1:0]      id_rs1, id_rs2, id_rd;
  logic [`RV_XLEN-1:0]        ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
  logic [`RV_REG_AW-1:0]      ex_rs1, ex_rs2, ex_rd, rf_rs1, rf_rs2;
  logic [`RV_XLEN-1:0]        ex_alu_result, ex_store_data, ex_target;
  logic                       ex_cmp_result, ex_redirect, ex_load_use;
  logic [`RV_XLEN-1:0]        mem_pc, mem_alu_result, mem_store_data, mem_result;
  logic                       mem_cmp_result;
  logic [`RV_REG_AW-1:0]      mem_rd, wb_rd;
  logic [`RV_XLEN-1:0]        wb_result, wb_rdata, wb_data;
  logic                       freeze, hold_front, flush_front, bubble_mem;
  logic                       advance_front;

  assign advance_front = !freeze && !hold_front;

  assign o_imem_addr = pc;
  assign o_imem_read = 1'b1;

  always_ff @(posedge clk) begin
    if (i_reset)
      pc <= `RV_RESET_PC;
    else if (advance_front)
      pc <= ex_redirect ? ex_target : pc + `RV_INSTR_BYTES;
  end

  // An all-zero IF/ID word decodes as a bubble
  always_ff @(posedge clk) begin
    if (i_reset || flush_front) begin
      id_instr <= '0;
    end else if (advance_front) begin
      id_instr <= i_imem_rdata;
      id_pc    <= pc;
    end
  end

  rv_decoder u_decoder (
    .i_instr (id_instr),
    .o_ctrl  (id_ctrl),
    .o_imm   (id_imm),
    .o_rs1   (id_rs1),
    .o_rs2   (id_rs2),
    .o_rd    (id_rd)
  );

  // On load-use the EX operands are read again so a WB write is not missed
  assign rf_rs1 = hold_front ? ex_rs1 : id_rs1;
  assign rf_rs2 = hold_front ? ex_rs2 : id_rs2;

  rv_regfile u_regfile (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_read_en  (!freeze),
    .i_rs1      (rf_rs1),
    .i_rs2      (rf_rs2),
    .i_we       (wb_ctrl.rd_valid && !freeze),
    .i_rd       (wb_rd),
    .i_wdata    (wb_data),
    .o_rs1_data (ex_rs1_data),
    .o_rs2_data (ex_rs2_data)
  );

  // ID/EX
  always_ff @(posedge clk) begin
    if (i_reset || flush_front)
      ex_ctrl <= '0;
    else if (advance_front)
      ex_ctrl <= id_ctrl;
  end

  always_ff @(posedge clk) begin
    if (advance_front) begin
      ex_pc  <= id_pc;
      ex_imm <= id_imm;
      ex_rs1 <= id_rs1;
      ex_rs2 <= id_rs2;
      ex_rd  <= id_rd;
    end
  end

  rv_execute u_execute (
    .i_ctrl       (ex_ctrl),
    .i_pc         (ex_pc),
    .i_imm        (ex_imm),
    .i_rs1        (ex_rs1),
    .i_rs2        (ex_rs2),
    .i_rs1_data   (ex_rs1_data),
    .i_rs2_data   (ex_rs2_data),
    .i_mem_rd     (mem_rd),
    .i_mem_ctrl   (mem_ctrl),
    .i_mem_result (mem_result),
    .i_wb_rd      (wb_rd),
    .i_wb_valid   (wb_ctrl.rd_valid),
    .i_wb_data    (wb_data),
    .o_alu_result (ex_alu_result),
    .o_cmp_result (ex_cmp_result),
    .o_store_data (ex_store_data),
    .o_target     (ex_target),
    .o_redirect   (ex_redirect),
    .o_load_use   (ex_load_use)
  );

  rv_hazard_unit u_hazard_unit (
    .i_imem_resp   (i_imem_resp),
    .i_dmem_resp   (i_dmem_resp),
    .i_dmem_access (o_dmem_read || o_dmem_write),
    .i_load_use    (ex_load_use),
    .i_redirect    (ex_redirect),
    .o_freeze      (freeze),
    .o_hold_front  (hold_front),
    .o_flush_front (flush_front),
    .o_bubble_mem  (bubble_mem)
  );

  // EX/MEM
  always_ff @(posedge clk) begin
    if (i_reset)
      mem_ctrl <= '0;
    else if (!freeze)
      mem_ctrl <= bubble_mem ? '0 : ex_ctrl;
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      mem_pc         <= ex_pc;
      mem_alu_result <= ex_alu_result;
      mem_cmp_result <= ex_cmp_result;
      mem_store_data <= ex_store_data;
      mem_rd         <= ex_rd;
    end
  end

  assign o_dmem_addr  = {mem_alu_result[`RV_XLEN-1:2], 2'b00}; // Word aligned
  assign o_dmem_read  = mem_ctrl.mem_read;
  assign o_dmem_write = mem_ctrl.mem_write;
  assign o_dmem_wdata = mem_store_data;

  // Result known in MEM and forwarded to EX
  always_comb begin
    case (mem_ctrl.wb_sel)
      rv_ctrl_pkg::wb_cmp: mem_result = {{(`RV_XLEN-1){1'b0}}, mem_cmp_result};
      rv_ctrl_pkg::wb_pc4: mem_result = mem_pc + `RV_INSTR_BYTES; // Link value
      default:             mem_result = mem_alu_result;
    endcase
  end

  // MEM/WB
  always_ff @(posedge clk) begin
    if (i_reset)
      wb_ctrl <= '0;
    else if (!freeze)
      wb_ctrl <= mem_ctrl;
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      wb_rd     <= mem_rd;
      wb_result <= mem_result;
      wb_rdata  <= i_dmem_rdata;
    end
  end

  assign wb_data = (wb_ctrl.wb_sel == rv_ctrl_pkg::wb_mem) ? wb_rdata : wb_result;

endmodule

/* testbench/rv_store_checker.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_store_checker (
  input  logic                clk,
  input  logic                i_reset,
  input  logic [`RV_XLEN-1:0] i_imem_addr,
  input  logic                i_imem_read,
  input  logic                i_imem_resp,
  input  logic [`RV_XLEN-1:0] i_dmem_addr,
  input  logic                i_dmem_read,
  input  logic                i_dmem_write,
  input  logic [`RV_XLEN-1:0] i_dmem_wdata,
  input  logic                i_dmem_resp,
  output int                  o_error_count,
  output logic                o_done
);

  localparam int RESET_TIMEOUT = 20;
  localparam int STORE_TIMEOUT = 400;  // Cycles allowed between two stores
  localparam int QUIET_CYCLES  = 40;   // Watch for stray stores at the end

  logic [`RV_XLEN-1:0] exp_addr [$];
  logic [`RV_XLEN-1:0] exp_data [$];
  logic                store_taken;
  int                  error_count;
  int                  strobe_errors = 0;

  // The core holds a store in MEM while fetch waits
  assign store_taken   = i_dmem_write && i_dmem_resp && i_imem_resp;
  assign o_error_count = error_count + strobe_errors;

  // Fetch is requested on every cycle out of reset
  always @(negedge clk) begin
    if (i_reset === 1'b0 && i_imem_read !== 1'b1) begin
      $display("[ERROR] %0t ns: imem read strobe is %b out of reset", $time, i_imem_read);
      strobe_errors++;
    end
  end

  task automatic read_expected_stores();
    integer              fd;
    integer              n;
    integer              c;
    logic [7:0]          tag;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] data;
    fd = $fopen("testbench/rv_core_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open testbench/rv_core_trace.txt for the expected stores");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", tag);
      if (n != 1)
        break;
      if (tag == "#") begin
        c = $fgetc(fd);                // Comment runs to end of line
        while (c != 10 && c != -1)
          c = $fgetc(fd);
      end else begin
        n = $fscanf(fd, "%h %h", addr, data);
        if (n == 2 && tag == "S") begin
          exp_addr.push_back(addr);
          exp_data.push_back(data);
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    int waited;
    int idx;
    error_count = 0;
    o_done      = 1'b0;
    read_expected_stores();
    if (exp_addr.size() == 0) begin
      $display("No expected stores were found in the trace");
      error_count++;
    end

    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (i_reset !== 1'b0 && waited < RESET_TIMEOUT);
    if (i_reset !== 1'b0) begin
      $display("Reset was never released");
      error_count++;
    end else if (i_imem_addr !== `RV_RESET_PC || i_dmem_read !== 1'b0 ||
                 i_dmem_write !== 1'b0) begin
      $display("[ERROR] %0t ns: after reset fetch %h, dmem read %b write %b",
               $time, i_imem_addr, i_dmem_read, i_dmem_write);
      error_count++;
    end

    for (idx = 0; idx < exp_addr.size(); idx++) begin
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (!store_taken && waited < STORE_TIMEOUT);
      if (!store_taken) begin
        $display("Timed out at %0t ns waiting for store %0d of %0d",
                 $time, idx + 1, exp_addr.size());
        error_count++;
        break;
      end
      if (i_dmem_addr !== exp_addr[idx] || i_dmem_wdata !== exp_data[idx]) begin
        $display("[ERROR] %0t ns: store %0d wrote %h at %h, expected %h at %h",
                 $time, idx + 1, i_dmem_wdata, i_dmem_addr, exp_data[idx], exp_addr[idx]);
        error_count++;
      end
    end

    // Squashed stores would show up here
    for (waited = 0; waited < QUIET_CYCLES; waited++) begin
      @(negedge clk);
      if (store_taken) begin
        $display("[ERROR] %0t ns: extra store of %h at %h after the last expected one",
                 $time, i_dmem_wdata, i_dmem_addr);
        error_count++;
      end
    end
    o_done = 1'b1;
  end

endmodule

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module tb_rv_core;

  localparam int MEM_WORDS    = 256;   // Both memories use address bits 9:2
  localparam int DONE_TIMEOUT = 5000;

  logic                clk = 1'b0;
  logic                reset;
  logic [`RV_XLEN-1:0] imem_addr;
  logic                imem_read;
  logic                imem_resp;
  logic [`RV_XLEN-1:0] imem_rdata;
  logic [`RV_XLEN-1:0] dmem_addr;
  logic                dmem_read;
  logic                dmem_write;
  logic [`RV_XLEN-1:0] dmem_wdata;
  logic                dmem_resp;
  logic [`RV_XLEN-1:0] dmem_rdata;
  logic [`RV_XLEN-1:0] imem [MEM_WORDS];
  logic [`RV_XLEN-1:0] dmem [MEM_WORDS];
  int                  error_count;
  logic                store_done;
  integer              seed;

  always #50 clk = ~clk;

  rv_core uut (
    .clk          (clk),
    .i_reset      (reset),
    .o_imem_addr  (imem_addr),
    .o_imem_read  (imem_read),
    .i_imem_resp  (imem_resp),
    .i_imem_rdata (imem_rdata),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_read  (dmem_read),
    .o_dmem_write (dmem_write),
    .o_dmem_wdata (dmem_wdata),
    .i_dmem_resp  (dmem_resp),
    .i_dmem_rdata (dmem_rdata)
  );

  rv_store_checker u_store_checker (
    .clk           (clk),
    .i_reset       (reset),
    .i_imem_addr   (imem_addr),
    .i_imem_read   (imem_read),
    .i_imem_resp   (imem_resp),
    .i_dmem_addr   (dmem_addr),
    .i_dmem_read   (dmem_read),
    .i_dmem_write  (dmem_write),
    .i_dmem_wdata  (dmem_wdata),
    .i_dmem_resp   (dmem_resp),
    .o_error_count (error_count),
    .o_done        (store_done)
  );

  // Memories answer in the same cycle
  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  task automatic load_trace();
    integer              fd;
    integer              n;
    integer              c;
    int                  i;
    logic [7:0]          tag;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] data;
    for (i = 0; i < MEM_WORDS; i++) begin
      imem[i[7:0]] = (i * 4) << 7;                // Opcode zero decodes as a bubble
      dmem[i[7:0]] = 32'hd000_0000 ^ (i * 4);
    end
    fd = $fopen("testbench/rv_core_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open testbench/rv_core_trace.txt for the program image");
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", tag);
      if (n != 1)
        break;
      if (tag == "#") begin
        c = $fgetc(fd);
        while (c != 10 && c != -1)
          c = $fgetc(fd);
      end else begin
        n = $fscanf(fd, "%h %h", addr, data);
        if (n == 2 && tag == "I")
          imem[addr[9:2]] = data;
        else if (n == 2 && tag == "D")
          dmem[addr[9:2]] = data;
      end
    end
    $fclose(fd);
  endtask

  // Program image load followed by the data write port
  initial begin
    load_trace();
    forever begin
      @(posedge clk);
      if (!reset && dmem_write && dmem_resp)
        dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  // Random wait states on about one cycle in four
  initial begin
    seed      = 32'h5b10;
    imem_resp = 1'b1;
    dmem_resp = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      imem_resp = ($random(seed) & 3) != 0;
      dmem_resp = ($random(seed) & 3) != 0;
    end
  end

  initial begin
    int cycles;
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    cycles = 0;
    while (!store_done && cycles < DONE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!store_done)
      $display("Timeout: the store checker did not finish in %0d cycles", DONE_TIMEOUT);
    $display("Store checks finished with %0d errors", error_count);
    if (!store_done || error_count != 0) begin
      $display("Simulation FAILED");
    end else begin
      $display("Simulation PASSED");
    end
    $finish;
  end

endmodule

/* testbench/rv_core_trace.txt */
# Columns: tag, byte address (hex), 32-bit word (hex); text after # is ignored
# Tags: I program word, D initial data word, S expected store in order
I 00000000 123450b7  # lui   x1, 0x12345
I 00000004 67808093  # addi  x1, x1, 0x678
I 00000008 00001117  # auipc x2, 0x1
I 0000000c 10102023  # sw    x1, 0x100(x0)
I 00000010 10202223  # sw    x2, 0x104(x0)
I 00000014 18002183  # lw    x3, 0x180(x0)
I 00000018 00118233  # add   x4, x3, x1
I 0000001c 403202b3  # sub   x5, x4, x3
I 00000020 10402423  # sw    x4, 0x108(x0)
I 00000024 ff000313  # addi  x6, x0, -16
I 00000028 40235393  # srai  x7, x6, 2
I 0000002c 01c35413  # srli  x8, x6, 28
I 00000030 0083c4b3  # xor   x9, x7, x8
I 00000034 00643533  # sltu  x10, x8, x6
I 00000038 000325b3  # slt   x11, x6, x0
I 0000003c 00b50633  # add   x12, x10, x11
I 00000040 10902623  # sw    x9, 0x10c(x0)
I 00000044 10c02823  # sw    x12, 0x110(x0)
I 00000048 00128463  # beq   x5, x1, +8 taken
I 0000004c 1e602823  # sw    x6, 0x1f0(x0) squashed
I 00000050 00129463  # bne   x5, x1, +8 not taken
I 00000054 10502a23  # sw    x5, 0x114(x0)
I 00000058 00605463  # bge   x0, x6, +8 taken
I 0000005c 1e602a23  # sw    x6, 0x1f4(x0) squashed
I 00000060 00836463  # bltu  x6, x8, +8 not taken
I 00000064 00c006ef  # jal   x13, +12
I 00000068 1e602c23  # sw    x6, 0x1f8(x0) squashed
I 0000006c 1e602e23  # sw    x6, 0x1fc(x0) squashed
I 00000070 01568767  # jalr  x14, 0x15(x13) lands on 0x7c
I 00000074 1e602c23  # sw    x6, 0x1f8(x0) squashed
I 00000078 1e602e23  # sw    x6, 0x1fc(x0) squashed
I 0000007c 10d02c23  # sw    x13, 0x118(x0)
I 00000080 10e02e23  # sw    x14, 0x11c(x0)
I 00000084 0000006f  # jal   x0, 0
D 00000180 00000064
S 00000100 12345678
S 00000104 00001008
S 00000108 123456dc
S 0000010c fffffff3
S 00000110 00000002
S 00000114 12345678
S 00000118 00000068
S 0000011c 00000074

/* sources.f */
+incdir+include
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_hazard_unit.sv
verilog/rv_core.sv
testbench/rv_store_checker.sv
testbench/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the RV32I core testbench with Verilator and runs it

cd "$(dirname "$0")" || { echo "Cannot enter the project directory"; exit 1; }

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_core -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_rv_core 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -qx "Simulation PASSED" <<< "$output"; then
  exit 0
fi
exit 1
